// File: verilog/dcp_pkg.sv
package dcp_pkg;

    // Widths with a meaning of their own.
    typedef logic [7:0]  char_t;     // One ASCII byte.
    typedef logic [31:0] word_t;     // One register value.
    typedef logic [4:0]  reg_addr_t; // Register index.
    typedef logic [7:0]  cmd_t;      // Held command letter.

    // Command codes are the ASCII letters themselves.
    localparam cmd_t cmd_none     = 8'h00;
    localparam cmd_t cmd_reg_dump = 8'h52; // R.

    // Literal characters of the dump format.
    localparam char_t chr_eq = 8'h3D;
    localparam char_t chr_cr = 8'h0D;
    localparam char_t chr_lf = 8'h0A;

    // Bases for digits and letters in printed values.
    localparam char_t chr_0 = 8'h30;
    localparam char_t chr_a = 8'h41;

endpackage

// File: verilog/dcp_cmd_decoder.sv
module dcp_cmd_decoder import dcp_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  rx_valid,
    input  char_t rx_data,
    input  logic  finish,
    output cmd_t  sel_mode,
    output logic  busy
);

    logic known_cmd;
    logic idle;

    // Only listed commands get latched.
    always_comb begin
        case (rx_data)
            cmd_reg_dump: known_cmd = 1'b1;
            default:      known_cmd = 1'b0;
        endcase
    end

    assign idle = (sel_mode == cmd_none);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sel_mode <= cmd_none;
        end else if (finish) begin
            sel_mode <= cmd_none; // Command done.
        end else if (rx_valid && known_cmd && idle) begin
            sel_mode <= cmd_t'(rx_data);
        end
    end

    assign busy = !idle;

    // The running command may only finish while one is held.
    a_finish_when_busy: assert property (
        @(posedge clk) disable iff (!rstn)
        finish |-> busy
    );

endmodule

// File: verilog/dcp_reg_dump.sv
module dcp_reg_dump import dcp_pkg::*; #(
    parameter cmd_t cmd_code = cmd_reg_dump
) (
    input  logic      clk,
    input  logic      rstn,
    input  cmd_t      sel_mode,
    output logic      finish,
    output logic      req_tx,
    output logic      type_tx,
    output word_t     dout_tx,
    input  logic      ack_tx,
    output reg_addr_t rf_addr,
    input  word_t     rf_data
);

    typedef enum logic [2:0] {
        INIT,
        PRINT_R,
        PRINT_ADDR,
        PRINT_EQ,
        FETCH,
        PRINT_DATA,
        NEXT,
        FINISH
    } state_t;

    state_t    state;
    reg_addr_t reg_cnt;
    logic      eol;      // Set once CR is out, LF follows.
    word_t     data_q;
    char_t     addr_chr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= INIT;
            req_tx  <= 1'b0;
            finish  <= 1'b0;
            reg_cnt <= '0;
            eol     <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (sel_mode != cmd_code) begin
                // Command withdrawn, abandon the dump.
                state   <= INIT;
                req_tx  <= 1'b0;
                reg_cnt <= '0;
                eol     <= 1'b0;
            end else begin
                case (state)
                    INIT: begin
                        req_tx  <= 1'b0;
                        reg_cnt <= '0;
                        eol     <= 1'b0;
                        if (!finish)
                            state <= PRINT_R; // Wait out our own finish pulse.
                    end
                    PRINT_R: begin
                        req_tx <= !ack_tx;
                        if (ack_tx)
                            state <= PRINT_ADDR;
                    end
                    PRINT_ADDR: begin
                        req_tx <= !ack_tx;
                        if (ack_tx)
                            state <= PRINT_EQ;
                    end
                    PRINT_EQ: begin
                        req_tx <= !ack_tx;
                        if (ack_tx)
                            state <= FETCH;
                    end
                    FETCH: begin
                        state <= PRINT_DATA;
                    end
                    PRINT_DATA: begin
                        req_tx <= !ack_tx;
                        if (ack_tx)
                            state <= NEXT;
                    end
                    NEXT: begin
                        reg_cnt <= reg_cnt + 5'd1;
                        state   <= (&reg_cnt) ? FINISH : PRINT_R; // Wraps after 31.
                    end
                    FINISH: begin
                        req_tx <= !ack_tx;
                        if (ack_tx) begin
                            if (eol) begin
                                eol    <= 1'b0;
                                finish <= 1'b1;
                                state  <= INIT;
                            end else begin
                                eol <= 1'b1;
                            end
                        end
                    end
                    default: state <= INIT;
                endcase
            end
        end
    end

    // Snapshot so the word stays put while it is printed.
    always_ff @(posedge clk) begin
        if (state == FETCH)
            data_q <= rf_data;
    end

    assign rf_addr = reg_cnt;

    assign addr_chr = (reg_cnt < 5'd10) ? chr_0 + char_t'(reg_cnt)
                                        : chr_a + char_t'(reg_cnt - 5'd10);

    always_comb begin
        type_tx = 1'b0;
        case (state)
            PRINT_R:    dout_tx = word_t'(cmd_code); // Line starts with the command letter.
            PRINT_ADDR: dout_tx = word_t'(addr_chr);
            PRINT_EQ:   dout_tx = word_t'(chr_eq);
            PRINT_DATA: begin
                type_tx = 1'b1;
                dout_tx = data_q;
            end
            FINISH:     dout_tx = word_t'(eol ? chr_lf : chr_cr);
            default:    dout_tx = '0;
        endcase
    end

    // Ack only answers a pending request, one item at a time.
    a_req_drops_after_ack: assert property (
        @(posedge clk) disable iff (!rstn)
        ack_tx |-> req_tx ##1 !req_tx
    );

endmodule

// File: verilog/dcp_tx_formatter.sv
module dcp_tx_formatter import dcp_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  req_tx,
    input  logic  type_tx,
    input  word_t dout_tx,
    output logic  ack_tx,
    output logic  tx_start,
    output char_t tx_data,
    input  logic  tx_busy
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_FREE,
        SEND,
        HOLD
    } state_t;

    state_t     state;
    word_t      shift_q;
    logic       word_q;    // Item is a hex word.
    logic       done_q;    // Last byte of the item went out.
    logic [2:0] digit_cnt;
    logic       last_byte;

    function automatic char_t hex_char(input logic [3:0] nib);
        char_t c;
        if (nib < 4'd10)
            c = chr_0 + char_t'(nib);
        else
            c = chr_a + char_t'(nib - 4'd10); // Uppercase A to F.
        return c;
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= IDLE;
            word_q    <= 1'b0;
            done_q    <= 1'b0;
            digit_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_tx) begin
                        word_q    <= type_tx;
                        done_q    <= 1'b0;
                        digit_cnt <= '0;
                        state     <= tx_busy ? WAIT_FREE : SEND;
                    end
                end
                WAIT_FREE: begin
                    if (!tx_busy)
                        state <= SEND;
                end
                SEND: begin
                    digit_cnt <= digit_cnt + 3'd1;
                    done_q    <= last_byte;
                    state     <= HOLD;
                end
                HOLD: begin
                    // Busy rises in this cycle, so it is not looked at here.
                    state <= done_q ? IDLE : WAIT_FREE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req_tx)
            shift_q <= dout_tx;
        else if (state == SEND)
            shift_q <= {shift_q[27:0], 4'h0}; // Next digit to the top.
    end

    assign last_byte = !word_q || (digit_cnt == 3'd7);

    assign tx_start = (state == SEND);
    assign ack_tx   = (state == SEND) && last_byte;
    assign tx_data  = word_q ? hex_char(shift_q[31:28]) : shift_q[7:0];

    // Transmitter must never see a start while it is still busy.
    a_no_start_when_busy: assert property (
        @(posedge clk) disable iff (!rstn)
        tx_start |-> !tx_busy
    );

endmodule

// File: verilog/dcp_reg_file.sv
module dcp_reg_file import dcp_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    input  reg_addr_t rd_addr,
    output word_t     rd_data
);

    word_t regs [0:31];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data; // x0 is hardwired.
        end
    end

    // Debug port, combinational.
    assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

// File: verilog/dcp_top.sv
module dcp_top import dcp_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      rx_valid,
    input  char_t     rx_data,
    output logic      busy,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output logic      tx_start,
    output char_t     tx_data,
    input  logic      tx_busy
);

    cmd_t      sel_mode;
    logic      finish;
    reg_addr_t rf_addr;
    word_t     rf_data;
    logic      req_tx;
    logic      type_tx;
    word_t     dout_tx;
    logic      ack_tx;

    dcp_cmd_decoder u_cmd_decoder (
        .clk      (clk),
        .rstn     (rstn),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .finish   (finish),
        .sel_mode (sel_mode),
        .busy     (busy)
    );

    dcp_reg_dump #(
        .cmd_code (cmd_reg_dump)
    ) u_reg_dump (
        .clk      (clk),
        .rstn     (rstn),
        .sel_mode (sel_mode),
        .finish   (finish),
        .req_tx   (req_tx),
        .type_tx  (type_tx),
        .dout_tx  (dout_tx),
        .ack_tx   (ack_tx),
        .rf_addr  (rf_addr),
        .rf_data  (rf_data)
    );

    dcp_tx_formatter u_tx_formatter (
        .clk      (clk),
        .rstn     (rstn),
        .req_tx   (req_tx),
        .type_tx  (type_tx),
        .dout_tx  (dout_tx),
        .ack_tx   (ack_tx),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy)
    );

    dcp_reg_file u_reg_file (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rf_addr),
        .rd_data (rf_data)
    );

endmodule

// File: sim/tb_clock.sv
module tb_clock #(
    parameter int period = 40
) (
    output logic clk
);

    // Free running, starts low.
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2);
            clk = ~clk;
        end
    end

endmodule

// File: sim/dcp_tb.sv
module dcp_tb import dcp_pkg::*; ();

    localparam int clk_period      = 40;
    localparam int dump_bytes      = 354;
    localparam int cycles_per_byte = 10;
    localparam int dump_cycles     = dump_bytes * cycles_per_byte;
    localparam int n_dumps         = 3;
    localparam int margin_cycles   = 2000; // Reset, writes and idle tests.
    localparam int watchdog_time   = (n_dumps * dump_cycles + margin_cycles) * clk_period;

    logic      clk;
    logic      rstn;
    logic      rx_valid;
    char_t     rx_data;
    logic      busy;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;
    logic      tx_start;
    char_t     tx_data;
    logic      tx_busy;

    integer seed = 9;
    word_t  shadow [0:31];
    char_t  got_q [$];  // Bytes seen by the transmitter model.
    char_t  exp_q [$];  // Expected answer.
    int     byte_idx;
    int     errors;
    int     err_at_start;
    int     test_no;
    int     n_pass;
    int     n_fail;

    tb_clock #(.period(clk_period)) clock_i (.clk(clk));

    dcp_top dut_i (
        .clk      (clk),
        .rstn     (rstn),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .busy     (busy),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy)
    );

    function automatic char_t hex_ascii(input logic [3:0] n);
        return (n < 4'd10) ? char_t'(8'h30 + n) : char_t'(8'h41 + n - 4'd10);
    endfunction

    // Expected dump from the shadow registers.
    function automatic void ref_dump();
        word_t v;
        exp_q.delete();
        for (int r = 0; r < 32; r++) begin
            v = shadow[r];
            exp_q.push_back(8'h52); // Letter R.
            exp_q.push_back((r < 10) ? char_t'(8'h30 + r) : char_t'(8'h41 + r - 10));
            exp_q.push_back(chr_eq);
            for (int d = 7; d >= 0; d--)
                exp_q.push_back(hex_ascii(v[d*4 +: 4]));
        end
        exp_q.push_back(chr_cr);
        exp_q.push_back(chr_lf);
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected 0x%0h, got 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        test_no++;
        if (errors == err_at_start)
            n_pass++;
        else
            n_fail++;
        $display("Test %0d, %s: %s", test_no, name, (errors == err_at_start) ? "pass" : "FAIL");
        err_at_start = errors;
    endtask

    task automatic write_reg(input reg_addr_t a, input word_t v);
        wr_en   = 1'b1;
        wr_addr = a;
        wr_data = v;
        @(negedge clk);
        wr_en   = 1'b0;
        shadow[a] = (a == 5'd0) ? '0 : v; // x0 stays zero.
    endtask

    task automatic fill_regs();
        for (int r = 0; r < 32; r++)
            write_reg(reg_addr_t'(r), $random(seed));
    endtask

    task automatic send_byte(input char_t b);
        rx_valid = 1'b1;
        rx_data  = b;
        @(negedge clk);
        rx_valid = 1'b0;
        rx_data  = 8'h00;
    endtask

    task automatic wait_busy(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (busy !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (busy !== level) begin
            $display("Busy did not go to %0b within %0d cycles", level, max_cycles);
            errors++;
        end
    endtask

    task automatic start_dump();
        ref_dump();
        byte_idx = 0;
        send_byte(8'h52);
        wait_busy(1'b1, 4);
    endtask

    task automatic finish_dump();
        wait_busy(1'b0, dump_cycles);
        repeat (20) @(negedge clk); // No second dump may follow.
        check_val("tx byte count", dump_bytes, byte_idx);
        check_val("busy", 0, busy);
    endtask

    // Transmitter model.
    initial begin : tx_model
        int hold;
        tx_busy = 1'b0;
        forever begin
            @(negedge clk);
            if (tx_start === 1'b1) begin
                got_q.push_back(tx_data);
                hold = 1 + ($unsigned($random(seed)) % 6);
                @(negedge clk);
                tx_busy = 1'b1; // One cycle after the start.
                repeat (hold) @(negedge clk);
                tx_busy = 1'b0;
            end
        end
    end

    always @(posedge clk) begin : compare_bytes
        char_t b;
        while (got_q.size() > 0) begin
            b = got_q.pop_front();
            if (byte_idx < exp_q.size()) begin
                check_val($sformatf("tx_data[%0d]", byte_idx), exp_q[byte_idx], b);
            end else begin
                $display("Byte 0x%02h arrived at index %0d where none was expected", b, byte_idx);
                errors++;
            end
            byte_idx++;
        end
    end

    initial begin : watchdog
        #(watchdog_time);
        $display("Run timed out after %0d time units before the tests completed", watchdog_time);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : stimulus
        int n;
        rstn     = 1'b0;
        rx_valid = 1'b0;
        rx_data  = 8'h00;
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        errors       = 0;
        err_at_start = 0;
        test_no      = 0;
        n_pass       = 0;
        n_fail       = 0;
        byte_idx     = 0;
        for (int r = 0; r < 32; r++)
            shadow[r] = '0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;

        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_val("busy", 0, busy);
            check_val("tx_start", 0, tx_start);
        end
        check_val("tx byte count", 0, byte_idx);
        end_test("idle after reset");

        fill_regs();
        start_dump();
        finish_dump();
        end_test("register dump");

        exp_q.delete();
        byte_idx = 0;
        send_byte(8'h51); // Q is not a command.
        for (int i = 0; i < 50; i++) begin
            check_val("busy", 0, busy);
            check_val("tx_start", 0, tx_start);
            @(negedge clk);
        end
        check_val("tx byte count", 0, byte_idx);
        end_test("unknown command");

        start_dump();
        n = 0;
        while (byte_idx < 120 && n < dump_cycles) begin
            @(negedge clk);
            n++;
        end
        if (byte_idx < 120) begin
            $display("Dump stalled before byte 120");
            errors++;
        end
        send_byte(8'h52);
        finish_dump();
        end_test("command during dump");

        fill_regs();
        start_dump();
        finish_dump();
        end_test("dump after rewrite");

        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
verilog/dcp_pkg.sv
verilog/dcp_cmd_decoder.sv
verilog/dcp_reg_dump.sv
verilog/dcp_tx_formatter.sv
verilog/dcp_reg_file.sv
verilog/dcp_top.sv
sim/tb_clock.sv
sim/dcp_tb.sv
